// ==== logic/core_pkg.sv ====
package core_pkg;

    // --------------------
    // datapath
    // --------------------
    localparam int DATA_BIT     = 32;
    localparam int IMM_BIT      = 16;
    localparam int REG_ADDR_BIT = 5;
    localparam int PC_BIT       = 12;  // pc_4 as carried down the pipe

    localparam logic [REG_ADDR_BIT-1:0] LINK_REG = 5'd31;  // jal destination

    // --------------------
    // data memory
    // --------------------
    localparam int DM_ADDR_BIT = 10;  // word address
    localparam int DM_WORDS    = 1 << DM_ADDR_BIT;

endpackage

// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

    // --------------------
    // memory stage
    // --------------------
    typedef enum logic [2:0] {
        MEM_W  = 3'd0,  // reset value
        MEM_H  = 3'd1,
        MEM_HU = 3'd2,
        MEM_B  = 3'd3,
        MEM_BU = 3'd4
    } mem_op_e;

    // --------------------
    // writeback stage
    // --------------------
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2,
        WB_LUI = 2'd3
    } wb_data_sel_e;

    typedef enum logic [1:0] {
        DEST_RD   = 2'd0,
        DEST_RT   = 2'd1,
        DEST_LINK = 2'd2
    } wb_dest_sel_e;

endpackage

// ==== logic/ex_mem_reg.sv ====
module ex_mem_reg (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               en,
    input  logic [core_pkg::DATA_BIT-1:0]      alu_res_in,
    input  logic [core_pkg::DATA_BIT-1:0]      store_data_in,
    input  logic [core_pkg::IMM_BIT-1:0]       imm16_in,
    input  logic [core_pkg::PC_BIT-1:0]        pc_4_in,
    input  logic [core_pkg::REG_ADDR_BIT-1:0]  rd_in,
    input  logic [core_pkg::REG_ADDR_BIT-1:0]  rt_in,
    input  ctrl_pkg::mem_op_e                  mem_op_in,
    input  logic                               mem_w_en_in,
    input  ctrl_pkg::wb_data_sel_e             wb_data_sel_in,
    input  ctrl_pkg::wb_dest_sel_e             wb_dest_sel_in,
    input  logic                               reg_w_en_in,
    input  logic                               halt_in,
    output logic [core_pkg::DATA_BIT-1:0]      alu_res,
    output logic [core_pkg::DATA_BIT-1:0]      store_data,
    output logic [core_pkg::IMM_BIT-1:0]       imm16,
    output logic [core_pkg::PC_BIT-1:0]        pc_4,
    output logic [core_pkg::REG_ADDR_BIT-1:0]  rd,
    output logic [core_pkg::REG_ADDR_BIT-1:0]  rt,
    output ctrl_pkg::mem_op_e                  mem_op,
    output logic                               mem_w_en,
    output ctrl_pkg::wb_data_sel_e             wb_data_sel,
    output ctrl_pkg::wb_dest_sel_e             wb_dest_sel,
    output logic                               reg_w_en,
    output logic                               halt
);

    import ctrl_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_res     <= '0;
            store_data  <= '0;
            imm16       <= '0;
            pc_4        <= '0;
            rd          <= '0;
            rt          <= '0;
            mem_op      <= MEM_W;
            mem_w_en    <= 1'b0;
            wb_data_sel <= WB_ALU;
            wb_dest_sel <= DEST_RD;
            reg_w_en    <= 1'b0;
            halt        <= 1'b0;
        end else if (en) begin  // hold while stalled
            alu_res     <= alu_res_in;
            store_data  <= store_data_in;
            imm16       <= imm16_in;
            pc_4        <= pc_4_in;
            rd          <= rd_in;
            rt          <= rt_in;
            mem_op      <= mem_op_in;
            mem_w_en    <= mem_w_en_in;
            wb_data_sel <= wb_data_sel_in;
            wb_dest_sel <= wb_dest_sel_in;
            reg_w_en    <= reg_w_en_in;
            halt        <= halt_in;
        end
    end

endmodule

// ==== logic/data_mem.sv ====
module data_mem (
    input  logic                           clk,
    input  logic                           en,
    input  logic [core_pkg::DATA_BIT-1:0]  addr,
    input  logic [core_pkg::DATA_BIT-1:0]  store_data,
    input  ctrl_pkg::mem_op_e              mem_op,
    input  logic                           mem_w_en,
    output logic [core_pkg::DATA_BIT-1:0]  load_data
);

    import core_pkg::*;
    import ctrl_pkg::*;

    logic [3:0][7:0]         mem [DM_WORDS];  // byte lanes, little-endian
    logic [DM_ADDR_BIT-1:0]  word_addr;
    logic [1:0]              byte_off;
    logic [3:0]              byte_mask;
    logic [3:0][7:0]         store_lanes;
    logic [3:0][7:0]         rd_word;
    logic [15:0]             rd_half;
    logic [7:0]              rd_byte;

    assign word_addr = addr[DM_ADDR_BIT+1:2];  // upper bits ignored
    assign byte_off  = addr[1:0];

    // --------------------
    // store alignment
    // --------------------
    always_comb begin
        byte_mask   = 4'b0000;
        store_lanes = store_data;
        case (mem_op)
            MEM_W: begin
                byte_mask = 4'b1111;
            end
            MEM_H, MEM_HU: begin
                byte_mask   = byte_off[1] ? 4'b1100 : 4'b0011;
                store_lanes = {2{store_data[15:0]}};
            end
            MEM_B, MEM_BU: begin
                byte_mask   = 4'b0001 << byte_off;
                store_lanes = {4{store_data[7:0]}};
            end
            default: begin
                byte_mask = 4'b0000;  // unknown op writes nothing
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (en && mem_w_en) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_mask[i]) mem[word_addr][i] <= store_lanes[i];
            end
        end
    end

    // --------------------
    // load extract and extend
    // --------------------
    assign rd_word = mem[word_addr];
    assign rd_half = byte_off[1] ? rd_word[3:2] : rd_word[1:0];
    assign rd_byte = rd_word[byte_off];

    always_comb begin
        case (mem_op)
            MEM_H:   load_data = {{(DATA_BIT-16){rd_half[15]}}, rd_half};
            MEM_HU:  load_data = {{(DATA_BIT-16){1'b0}}, rd_half};
            MEM_B:   load_data = {{(DATA_BIT-8){rd_byte[7]}}, rd_byte};
            MEM_BU:  load_data = {{(DATA_BIT-8){1'b0}}, rd_byte};
            default: load_data = rd_word;  // MEM_W
        endcase
    end

endmodule

// ==== logic/mem_wb_reg.sv ====
module mem_wb_reg (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               en,
    input  logic [core_pkg::DATA_BIT-1:0]      alu_res,
    input  logic [core_pkg::DATA_BIT-1:0]      load_data,
    input  logic [core_pkg::PC_BIT-1:0]        pc_4,
    input  logic [core_pkg::IMM_BIT-1:0]       imm16,
    input  logic [core_pkg::REG_ADDR_BIT-1:0]  rd,
    input  logic [core_pkg::REG_ADDR_BIT-1:0]  rt,
    input  ctrl_pkg::wb_data_sel_e             wb_data_sel,
    input  ctrl_pkg::wb_dest_sel_e             wb_dest_sel,
    input  logic                               reg_w_en_in,
    input  logic                               halt_in,
    output logic                               reg_w_en,
    output logic [core_pkg::REG_ADDR_BIT-1:0]  reg_w_addr,
    output logic [core_pkg::DATA_BIT-1:0]      reg_w_data,
    output logic                               halt
);

    import core_pkg::*;
    import ctrl_pkg::*;

    logic [DATA_BIT-1:0]      wb_data;
    logic [REG_ADDR_BIT-1:0]  wb_dest;

    // --------------------
    // writeback selects
    // --------------------
    always_comb begin
        case (wb_data_sel)
            WB_MEM:  wb_data = load_data;
            WB_PC4:  wb_data = {{(DATA_BIT-PC_BIT){1'b0}}, pc_4};
            WB_LUI:  wb_data = {imm16, {(DATA_BIT-IMM_BIT){1'b0}}};
            default: wb_data = alu_res;  // WB_ALU
        endcase
    end

    always_comb begin
        case (wb_dest_sel)
            DEST_RT:   wb_dest = rt;
            DEST_LINK: wb_dest = LINK_REG;
            default:   wb_dest = rd;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_w_en   <= 1'b0;
            reg_w_addr <= '0;
            reg_w_data <= '0;
            halt       <= 1'b0;
        end else if (en) begin
            reg_w_en   <= reg_w_en_in;
            reg_w_addr <= wb_dest;
            reg_w_data <= wb_data;
            halt       <= halt | halt_in;  // sticky until reset
        end
    end

endmodule

// ==== logic/mem_wb_top.sv ====
module mem_wb_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               en,
    input  logic [core_pkg::DATA_BIT-1:0]      alu_res_in,
    input  logic [core_pkg::DATA_BIT-1:0]      store_data_in,
    input  logic [core_pkg::IMM_BIT-1:0]       imm16_in,
    input  logic [core_pkg::PC_BIT-1:0]        pc_4_in,
    input  logic [core_pkg::REG_ADDR_BIT-1:0]  rd_in,
    input  logic [core_pkg::REG_ADDR_BIT-1:0]  rt_in,
    input  ctrl_pkg::mem_op_e                  mem_op_in,
    input  logic                               mem_w_en_in,
    input  ctrl_pkg::wb_data_sel_e             wb_data_sel_in,
    input  ctrl_pkg::wb_dest_sel_e             wb_dest_sel_in,
    input  logic                               reg_w_en_in,
    input  logic                               halt_in,
    output logic                               reg_w_en,
    output logic [core_pkg::REG_ADDR_BIT-1:0]  reg_w_addr,
    output logic [core_pkg::DATA_BIT-1:0]      reg_w_data,
    output logic                               halt
);

    import core_pkg::*;
    import ctrl_pkg::*;

    // memory stage fields
    logic [DATA_BIT-1:0]      alu_res;
    logic [DATA_BIT-1:0]      store_data;
    logic [IMM_BIT-1:0]       imm16;
    logic [PC_BIT-1:0]        pc_4;
    logic [REG_ADDR_BIT-1:0]  rd;
    logic [REG_ADDR_BIT-1:0]  rt;
    mem_op_e                  mem_op;
    logic                     mem_w_en;
    wb_data_sel_e             wb_data_sel;
    wb_dest_sel_e             wb_dest_sel;
    logic                     mem_reg_w_en;
    logic                     mem_halt;
    logic [DATA_BIT-1:0]      load_data;

    ex_mem_reg i_ex_mem_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .en             (en),
        .alu_res_in     (alu_res_in),
        .store_data_in  (store_data_in),
        .imm16_in       (imm16_in),
        .pc_4_in        (pc_4_in),
        .rd_in          (rd_in),
        .rt_in          (rt_in),
        .mem_op_in      (mem_op_in),
        .mem_w_en_in    (mem_w_en_in),
        .wb_data_sel_in (wb_data_sel_in),
        .wb_dest_sel_in (wb_dest_sel_in),
        .reg_w_en_in    (reg_w_en_in),
        .halt_in        (halt_in),
        .alu_res        (alu_res),
        .store_data     (store_data),
        .imm16          (imm16),
        .pc_4           (pc_4),
        .rd             (rd),
        .rt             (rt),
        .mem_op         (mem_op),
        .mem_w_en       (mem_w_en),
        .wb_data_sel    (wb_data_sel),
        .wb_dest_sel    (wb_dest_sel),
        .reg_w_en       (mem_reg_w_en),
        .halt           (mem_halt)
    );

    data_mem i_data_mem (
        .clk        (clk),
        .en         (en),
        .addr       (alu_res),  // byte address from the ALU
        .store_data (store_data),
        .mem_op     (mem_op),
        .mem_w_en   (mem_w_en),
        .load_data  (load_data)
    );

    mem_wb_reg i_mem_wb_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .alu_res     (alu_res),
        .load_data   (load_data),
        .pc_4        (pc_4),
        .imm16       (imm16),
        .rd          (rd),
        .rt          (rt),
        .wb_data_sel (wb_data_sel),
        .wb_dest_sel (wb_dest_sel),
        .reg_w_en_in (mem_reg_w_en),
        .halt_in     (mem_halt),
        .reg_w_en    (reg_w_en),
        .reg_w_addr  (reg_w_addr),
        .reg_w_data  (reg_w_data),
        .halt        (halt)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;  // end of reset
    end

endmodule

// ==== dv/tb_mem_wb.sv ====
module tb_mem_wb;

    timeunit 1ns;
    timeprecision 100ps;

    import ctrl_pkg::*;

    logic clk, rst_n, en, mem_w_en_in, reg_w_en_in, halt_in;
    logic [31:0] alu_res_in, store_data_in, reg_w_data;
    logic [15:0] imm16_in;
    logic [11:0] pc_4_in;
    logic [4:0] rd_in, rt_in, reg_w_addr;
    mem_op_e mem_op_in;
    wb_data_sel_e wb_data_sel_in;
    wb_dest_sel_e wb_dest_sel_in;
    logic reg_w_en, halt;

    // reference pipeline from the stage rules
    logic [31:0] s1_alu, s1_sd, exp_data, rnd, held_data;
    logic [15:0] s1_imm;
    logic [11:0] s1_pc;
    logic [4:0] s1_rd, s1_rt, exp_addr, dest;
    mem_op_e s1_op;
    wb_data_sel_e s1_ws;
    wb_dest_sel_e s1_ds;
    logic s1_mw, s1_rwe, s1_halt, exp_en, exp_halt, armed;
    logic [7:0] shadow [4096];  // byte-wide shadow memory
    int seed = 32'h456;
    int errors = 0;
    int checks = 0;
    int test_base = 0;
    int n;

    tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    mem_wb_top i_dut (.*);

    function automatic logic [31:0] load_value(logic [31:0] a, mem_op_e op);
        logic [11:0] w;
        logic [15:0] h;
        logic [7:0] b;
        w = {a[11:2], 2'b00};
        h = a[1] ? {shadow[w + 12'd3], shadow[w + 12'd2]} : {shadow[w + 12'd1], shadow[w]};
        b = shadow[a[11:0]];
        case (op)
            MEM_H:   return {{16{h[15]}}, h};
            MEM_HU:  return {16'h0, h};
            MEM_B:   return {{24{b[7]}}, b};
            MEM_BU:  return {24'h0, b};
            default: return {shadow[w + 12'd3], shadow[w + 12'd2], shadow[w + 12'd1], shadow[w]};
        endcase
    endfunction

    task automatic write_shadow(logic [31:0] a, logic [31:0] d, mem_op_e op);
        logic [11:0] base;
        case (op)
            MEM_W: begin
                base = {a[11:2], 2'b00};
                shadow[base] = d[7:0];
                shadow[base + 12'd1] = d[15:8];
                shadow[base + 12'd2] = d[23:16];
                shadow[base + 12'd3] = d[31:24];
            end
            MEM_H, MEM_HU: begin
                base = {a[11:1], 1'b0};
                shadow[base] = d[7:0];
                shadow[base + 12'd1] = d[15:8];
            end
            default: shadow[a[11:0]] = d[7:0];  // byte ops
        endcase
    endtask

    always_comb begin
        case (s1_ds)
            DEST_RT:   dest = s1_rt;
            DEST_LINK: dest = 5'd31;
            default:   dest = s1_rd;
        endcase
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {s1_alu, s1_sd, s1_imm, s1_pc, s1_rd, s1_rt} <= '0;
            {s1_mw, s1_rwe, s1_halt, exp_en, exp_halt, exp_addr, exp_data} <= '0;
            s1_op <= MEM_W;
            s1_ws <= WB_ALU;
            s1_ds <= DEST_RD;
        end else if (en) begin
            s1_alu <= alu_res_in;
            s1_sd <= store_data_in;
            s1_imm <= imm16_in;
            s1_pc <= pc_4_in;
            s1_rd <= rd_in;
            s1_rt <= rt_in;
            s1_op <= mem_op_in;
            s1_mw <= mem_w_en_in;
            s1_ws <= wb_data_sel_in;
            s1_ds <= wb_dest_sel_in;
            s1_rwe <= reg_w_en_in;
            s1_halt <= halt_in;
            exp_en <= s1_rwe;
            exp_addr <= dest;
            exp_halt <= exp_halt | s1_halt;
            case (s1_ws)
                WB_MEM:  exp_data <= load_value(s1_alu, s1_op);
                WB_PC4:  exp_data <= {20'h0, s1_pc};
                WB_LUI:  exp_data <= {s1_imm, 16'h0};
                default: exp_data <= s1_alu;
            endcase
            if (s1_mw) write_shadow(s1_alu, s1_sd, s1_op);  // after the load read
        end
    end

    // --------------------
    // checks
    // --------------------
    always @(negedge clk) begin
        if (armed) begin
            checks++;
            assert (reg_w_en === exp_en && reg_w_addr === exp_addr &&
                    reg_w_data === exp_data && halt === exp_halt)
            else begin
                errors++;
                $display("Error: %0d ns writeback mismatch (got/expected)", $time);
                $display("  en %0b/%0b addr %0d/%0d data %h/%h halt %0b/%0b",
                         reg_w_en, exp_en, reg_w_addr, exp_addr, reg_w_data, exp_data,
                         halt, exp_halt);
            end
            if (!rst_n) begin
                checks++;
                assert (reg_w_en == 1'b0 && halt == 1'b0)
                else begin
                    errors++;
                    $display("Error: %0d ns reg_w_en or halt high in reset", $time);
                end
            end
        end
    end

    task automatic send_op(logic [31:0] alu, logic [31:0] sd, logic [15:0] imm,
                           logic [11:0] pc, logic [4:0] rd, logic [4:0] rt, mem_op_e op,
                           logic mw, wb_data_sel_e ws, wb_dest_sel_e ds, logic rwe, logic h);
        @(posedge clk);
        en <= 1'b1;
        alu_res_in <= alu;
        store_data_in <= sd;
        imm16_in <= imm;
        pc_4_in <= pc;
        rd_in <= rd;
        rt_in <= rt;
        mem_op_in <= op;
        mem_w_en_in <= mw;
        wb_data_sel_in <= ws;
        wb_dest_sel_in <= ds;
        reg_w_en_in <= rwe;
        halt_in <= h;
    endtask

    task automatic store(logic [31:0] a, logic [31:0] d, mem_op_e op);
        send_op(a, d, 16'h0, 12'h0, 5'd0, 5'd0, op, 1'b1, WB_ALU, DEST_RD, 1'b0, 1'b0);
    endtask

    task automatic load(logic [31:0] a, mem_op_e op, logic [4:0] rd);
        send_op(a, 32'h0, 16'h0, 12'h0, rd, 5'd0, op, 1'b0, WB_MEM, DEST_RD, 1'b1, 1'b0);
    endtask

    task automatic nop();
        send_op(32'h0, 32'h0, 16'h0, 12'h0, 5'd0, 5'd0, MEM_W, 1'b0, WB_ALU, DEST_RD, 1'b0, 1'b0);
    endtask

    task automatic report(string name);
        $display("test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic give_up(string what);
        $display("timeout while waiting for %s", what);
        $display("TB FAILED");
        $finish;
    endtask

    initial begin
        wb_data_sel_e ws_list [3] = '{WB_ALU, WB_PC4, WB_LUI};
        wb_dest_sel_e ds_list [3] = '{DEST_RD, DEST_RT, DEST_LINK};
        mem_op_e op_list [2];
        armed = 1'b0;
        en = 1'b0;
        {alu_res_in, store_data_in, imm16_in, pc_4_in, rd_in, rt_in} = '0;
        {mem_w_en_in, reg_w_en_in, halt_in} = '0;
        mem_op_in = MEM_W;
        wb_data_sel_in = WB_ALU;
        wb_dest_sel_in = DEST_RD;
        @(posedge clk);
        armed = 1'b1;
        n = 0;
        while (!rst_n) begin
            if (n > 20) give_up("reset release");
            n++;
            @(posedge clk);
        end
        nop();
        nop();
        report("reset");

        foreach (ws_list[i]) begin
            foreach (ds_list[j]) begin
                rnd = $random(seed);
                send_op(rnd, 32'h0, rnd[31:16], rnd[11:0], rnd[4:0], rnd[9:5], MEM_W,
                        1'b0, ws_list[i], ds_list[j], 1'b1, 1'b0);
            end
        end
        nop();
        nop();
        report("alu_imm");

        for (int w = 0; w < 16; w++) store(w * 4, $random(seed), MEM_W);
        for (int k = 0; k < 24; k++) begin
            rnd = $random(seed);
            load({26'h0, rnd[5:2], rnd[1:0]}, MEM_W, rnd[10:6]);  // offsets ignored
        end
        nop();
        nop();
        report("word_mem");

        for (int off = 0; off < 4; off++) begin
            rnd = $random(seed);
            rnd[7] = off[0];  // both signs across the lanes
            store(32 + off, rnd, (off % 2) ? MEM_BU : MEM_B);
            load(32 + off, MEM_B, 5'd1);
            load(32 + off, MEM_BU, 5'd2);
            load(32, MEM_W, 5'd3);
        end
        op_list = '{MEM_H, MEM_HU};
        for (int off = 0; off < 4; off += 2) begin
            rnd = $random(seed);
            rnd[15] = (off == 0);
            store(40 + off, rnd, op_list[off / 2]);
            load(40 + off + 1, MEM_H, 5'd4);
            load(40 + off, MEM_HU, 5'd5);
            load(40, MEM_W, 5'd6);
        end
        nop();
        nop();
        report("sized");

        store(84, 32'h1111_2222, MEM_W);
        store(80, 32'hcafe_0001, MEM_W);
        @(posedge clk);
        en <= 1'b0;
        alu_res_in <= 32'd84;  // store seen only while stalled
        store_data_in <= 32'hdead_beef;
        @(negedge clk);
        held_data = reg_w_data;
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            checks++;
            assert (reg_w_data === held_data)
            else begin
                errors++;
                $display("Error: %0d ns output moved during stall", $time);
            end
        end
        @(posedge clk);
        store_data_in <= 32'h0;
        mem_w_en_in <= 1'b0;
        load(80, MEM_W, 5'd7);
        load(84, MEM_W, 5'd8);
        nop();
        nop();
        report("stall");

        send_op(32'h5, 32'h0, 16'h0, 12'h0, 5'd9, 5'd0, MEM_W, 1'b0, WB_ALU, DEST_RD,
                1'b1, 1'b1);
        nop();
        n = 0;
        while (!halt) begin
            if (n > 10) give_up("halt");
            n++;
            @(posedge clk);
        end
        repeat (4) nop();
        report("halt");

        $display("checks: %0d passed, %0d failed", checks - errors, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
logic/core_pkg.sv
logic/ctrl_pkg.sv
logic/ex_mem_reg.sv
logic/data_mem.sv
logic/mem_wb_reg.sv
logic/mem_wb_top.sv
dv/tb_clk_gen.sv
dv/tb_mem_wb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_wb \
    -f project.f -o sim_mem_wb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_mem_wb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
